/* logic/blimp_pkg.sv */
/*
 * Shared sizing and encodings for the out-of-order completion core slice.
 * ROB_DEPTH must equal 2**SEQ_W so that sequence numbers index the buffer.
 * Register addresses must cover NUM_REGS, so REG_AW = log2(NUM_REGS).
 */

package blimp_pkg;

  // ------------------------------
  // Sizing
  // ------------------------------

  // Datapath width
  localparam int DATA_W     = 32;
  // Architectural registers and their address width
  localparam int NUM_REGS   = 8;
  localparam int REG_AW     = 3;
  // Reorder buffer, one entry per sequence number
  localparam int ROB_DEPTH  = 8;
  localparam int SEQ_W      = 3;
  // Immediate field, zero-extended by OP_LI
  localparam int IMM_W      = 16;
  // Multiplier pipeline depth
  localparam int MUL_STAGES = 4;

  // ------------------------------
  // Encodings
  // ------------------------------

  // Opcodes; only OP_MUL goes to the multiplier
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_LI  = 3'd3,
    OP_MUL = 3'd4
  } blimp_op_e;

  // Decode stage register state
  typedef enum logic {
    D_EMPTY = 1'b0,
    D_HELD  = 1'b1
  } blimp_dstate_e;

endpackage

/* logic/blimp_x2w_if.sv */
/*
 * One completion from an execute pipe to the writeback/commit unit.
 * val is a single-cycle strobe; the receiver never back-pressures.
 */

`timescale 1ns/1ps

interface blimp_x2w_if ();

  import blimp_pkg::*;

  // Completion strobe
  logic              val;
  // Reorder-buffer tag of the finished instruction
  logic [SEQ_W-1:0]  seq_num;
  // Destination register and result
  logic [REG_AW-1:0] waddr;
  logic [DATA_W-1:0] wdata;

  // Execute pipe side
  modport pub (
    output val,
    output seq_num,
    output waddr,
    output wdata
  );

  // Commit unit side
  modport sub (
    input  val,
    input  seq_num,
    input  waddr,
    input  wdata
  );

endinterface

/* logic/blimp_reg_file.sv */
/*
 * Architectural register file, written only at commit.
 * Reads are combinational with no write bypass; a write shows up next cycle.
 */

`timescale 1ns/1ps

module blimp_reg_file (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [blimp_pkg::REG_AW-1:0]  raddr0,
  input  logic [blimp_pkg::REG_AW-1:0]  raddr1,
  input  logic                          wen,
  input  logic [blimp_pkg::REG_AW-1:0]  waddr,
  input  logic [blimp_pkg::DATA_W-1:0]  wdata,
  output logic [blimp_pkg::DATA_W-1:0]  rdata0,
  output logic [blimp_pkg::DATA_W-1:0]  rdata1
);

  import blimp_pkg::*;

  logic [DATA_W-1:0] regs_q [NUM_REGS];

  // Committed state, all zero out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen) begin
      regs_q[waddr] <= wdata;
    end
  end

  // Operand reads for the held instruction
  assign rdata0 = regs_q[raddr0];
  assign rdata1 = regs_q[raddr1];

endmodule

/* logic/blimp_seq_counter.sv */
/*
 * Sequence-number allocator for the reorder buffer.
 * Tail advances on issue, head on commit, both wrap modulo ROB_DEPTH.
 * Occupancy counts up to ROB_DEPTH, so full and empty stay distinct.
 */

`timescale 1ns/1ps

module blimp_seq_counter (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         issue,
  input  logic                         commit_val,
  output logic [blimp_pkg::SEQ_W-1:0]  alloc_seq,
  output logic [blimp_pkg::SEQ_W-1:0]  head_seq,
  output logic                         rob_full
);

  import blimp_pkg::*;

  logic [SEQ_W-1:0] tail_q;
  logic [SEQ_W-1:0] head_q;
  logic [SEQ_W:0]   occ_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail_q <= '0;
      head_q <= '0;
      occ_q  <= '0;
    end else begin
      // Pointers wrap by natural overflow
      if (issue) begin
        tail_q <= tail_q + 1'b1;
      end
      if (commit_val) begin
        head_q <= head_q + 1'b1;
      end
      // Issue and commit together cancel out
      case ({issue, commit_val})
        2'b10:   occ_q <= occ_q + 1'b1;
        2'b01:   occ_q <= occ_q - 1'b1;
        default: occ_q <= occ_q;
      endcase
    end
  end

  assign alloc_seq = tail_q;
  assign head_seq  = head_q;
  assign rob_full  = (occ_q == (SEQ_W + 1)'(ROB_DEPTH));

  // Decode must respect full
  a_no_issue_full : assert property (@(posedge clk) disable iff (!rst_n)
    issue |-> !rob_full);

  // Commit unit only drains live entries
  a_no_commit_empty : assert property (@(posedge clk) disable iff (!rst_n)
    commit_val |-> (occ_q != '0));

endmodule

/* logic/blimp_decode_issue.sv */
/*
 * In-order decode/issue stage holding one instruction.
 * A per-register scoreboard stalls on any pending write, no renaming.
 * A held instruction and a new one can swap in the same cycle.
 */

`timescale 1ns/1ps

module blimp_decode_issue (
  input  logic                          clk,
  input  logic                          rst_n,
  // Instruction in
  input  logic                          inst_val,
  input  blimp_pkg::blimp_op_e          inst_op,
  input  logic [blimp_pkg::REG_AW-1:0]  inst_waddr,
  input  logic [blimp_pkg::REG_AW-1:0]  inst_raddr0,
  input  logic [blimp_pkg::REG_AW-1:0]  inst_raddr1,
  input  logic [blimp_pkg::IMM_W-1:0]   inst_imm,
  output logic                          inst_stall,
  // Register file reads
  output logic [blimp_pkg::REG_AW-1:0]  raddr0,
  output logic [blimp_pkg::REG_AW-1:0]  raddr1,
  input  logic [blimp_pkg::DATA_W-1:0]  rdata0,
  input  logic [blimp_pkg::DATA_W-1:0]  rdata1,
  // Sequence allocation
  input  logic [blimp_pkg::SEQ_W-1:0]   alloc_seq,
  input  logic                          rob_full,
  output logic                          issue,
  // Commit notification
  input  logic                          commit_val,
  input  logic [blimp_pkg::REG_AW-1:0]  commit_waddr,
  // ALU dispatch
  output logic                          alu_val,
  output blimp_pkg::blimp_op_e          alu_op,
  output logic [blimp_pkg::DATA_W-1:0]  alu_a,
  output logic [blimp_pkg::DATA_W-1:0]  alu_b,
  output logic [blimp_pkg::SEQ_W-1:0]   alu_seq_num,
  output logic [blimp_pkg::REG_AW-1:0]  alu_waddr,
  // Multiplier dispatch
  output logic                          mul_val,
  output logic [blimp_pkg::DATA_W-1:0]  mul_a,
  output logic [blimp_pkg::DATA_W-1:0]  mul_b,
  output logic [blimp_pkg::SEQ_W-1:0]   mul_seq_num,
  output logic [blimp_pkg::REG_AW-1:0]  mul_waddr
);

  import blimp_pkg::*;

  blimp_dstate_e       state_q;
  blimp_op_e           st_op_q;
  logic [REG_AW-1:0]   st_waddr_q;
  logic [REG_AW-1:0]   st_raddr0_q;
  logic [REG_AW-1:0]   st_raddr1_q;
  logic [IMM_W-1:0]    st_imm_q;
  logic [NUM_REGS-1:0] sb_q;
  logic                hazard;
  logic                accept;
  logic [DATA_W-1:0]   opnd_a;

  // ------------------------------
  // Issue check
  // ------------------------------

  // Sources, destination and buffer space
  assign hazard = sb_q[st_raddr0_q] | sb_q[st_raddr1_q] | sb_q[st_waddr_q] | rob_full;

  assign issue      = (state_q == D_HELD) && !hazard;
  assign inst_stall = (state_q == D_HELD) && hazard;
  assign accept     = inst_val && !inst_stall;

  // ------------------------------
  // Stage FSM and register
  // ------------------------------

  // New arrival wins over an issue that empties the stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= D_EMPTY;
    end else if (accept) begin
      state_q <= D_HELD;
    end else if (issue) begin
      state_q <= D_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      st_op_q     <= inst_op;
      st_waddr_q  <= inst_waddr;
      st_raddr0_q <= inst_raddr0;
      st_raddr1_q <= inst_raddr1;
      st_imm_q    <= inst_imm;
    end
  end

  // ------------------------------
  // Scoreboard
  // ------------------------------

  // Commit clears, issue sets; never the same bit in one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sb_q <= '0;
    end else begin
      if (commit_val) begin
        sb_q[commit_waddr] <= 1'b0;
      end
      if (issue) begin
        sb_q[st_waddr_q] <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Operands and dispatch
  // ------------------------------

  assign raddr0 = st_raddr0_q;
  assign raddr1 = st_raddr1_q;

  // Load-immediate takes the zero-extended immediate as operand a
  assign opnd_a = (st_op_q == OP_LI) ? DATA_W'(st_imm_q) : rdata0;

  assign alu_val     = issue && (st_op_q != OP_MUL);
  assign alu_op      = st_op_q;
  assign alu_a       = opnd_a;
  assign alu_b       = rdata1;
  assign alu_seq_num = alloc_seq;
  assign alu_waddr   = st_waddr_q;

  assign mul_val     = issue && (st_op_q == OP_MUL);
  assign mul_a       = rdata0;
  assign mul_b       = rdata1;
  assign mul_seq_num = alloc_seq;
  assign mul_waddr   = st_waddr_q;

  // A set on a pending bit would leave a later commit with nothing to clear
  a_sb_clear_pending : assert property (@(posedge clk) disable iff (!rst_n)
    commit_val |-> sb_q[commit_waddr]);

endmodule

/* logic/blimp_alu_unit.sv */
/*
 * Single-cycle ALU pipe with add, subtract, and, load-immediate.
 * For OP_LI the immediate already sits in operand a.
 */

`timescale 1ns/1ps

module blimp_alu_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alu_val,
  input  blimp_pkg::blimp_op_e          op,
  input  logic [blimp_pkg::DATA_W-1:0]  a,
  input  logic [blimp_pkg::DATA_W-1:0]  b,
  input  logic [blimp_pkg::SEQ_W-1:0]   seq_num,
  input  logic [blimp_pkg::REG_AW-1:0]  waddr,
  blimp_x2w_if.pub                      x2w
);

  import blimp_pkg::*;

  logic [DATA_W-1:0] result;

  always_comb begin
    case (op)
      OP_ADD:  result = a + b;
      OP_SUB:  result = a - b;
      OP_AND:  result = a & b;
      OP_LI:   result = a;
      // OP_MUL never reaches this pipe
      default: result = a + b;
    endcase
  end

  // Completion strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x2w.val <= 1'b0;
    end else begin
      x2w.val <= alu_val;
    end
  end

  // Result with its tag
  always_ff @(posedge clk) begin
    if (alu_val) begin
      x2w.seq_num <= seq_num;
      x2w.waddr   <= waddr;
      x2w.wdata   <= result;
    end
  end

endmodule

/* logic/blimp_mul_unit.sv */
/*
 * Pipelined multiplier, MUL_STAGES deep, one new item per cycle.
 * Result is the low DATA_W bits of the product.
 */

`timescale 1ns/1ps

module blimp_mul_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          mul_val,
  input  logic [blimp_pkg::DATA_W-1:0]  a,
  input  logic [blimp_pkg::DATA_W-1:0]  b,
  input  logic [blimp_pkg::SEQ_W-1:0]   seq_num,
  input  logic [blimp_pkg::REG_AW-1:0]  waddr,
  blimp_x2w_if.pub                      x2w
);

  import blimp_pkg::*;

  logic [MUL_STAGES-1:0] val_q;
  logic [SEQ_W-1:0]      seq_q   [MUL_STAGES];
  logic [REG_AW-1:0]     waddr_q [MUL_STAGES];
  logic [DATA_W-1:0]     prod_q  [MUL_STAGES];
  logic [DATA_W-1:0]     prod_lo;

  // Low half only
  assign prod_lo = a * b;

  // Valid bits shift in with each new dispatch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_q <= '0;
    end else begin
      val_q <= {val_q[MUL_STAGES-2:0], mul_val};
    end
  end

  // Product and tag travel together, every stage independent
  always_ff @(posedge clk) begin
    seq_q[0]   <= seq_num;
    waddr_q[0] <= waddr;
    prod_q[0]  <= prod_lo;
    for (int s = 1; s < MUL_STAGES; s++) begin
      seq_q[s]   <= seq_q[s-1];
      waddr_q[s] <= waddr_q[s-1];
      prod_q[s]  <= prod_q[s-1];
    end
  end

  // Last stage completes
  assign x2w.val     = val_q[MUL_STAGES-1];
  assign x2w.seq_num = seq_q[MUL_STAGES-1];
  assign x2w.waddr   = waddr_q[MUL_STAGES-1];
  assign x2w.wdata   = prod_q[MUL_STAGES-1];

endmodule

/* logic/blimp_writeback_commit.sv */
/*
 * Reorder buffer written by completion tag, drained in order from the head.
 * Accepts one ALU and one multiplier completion per cycle, no back-pressure.
 * Commit is combinational from the head entry; the trace is registered.
 */

`timescale 1ns/1ps

module blimp_writeback_commit (
  input  logic                          clk,
  input  logic                          rst_n,
  blimp_x2w_if.sub                      alu_x2w,
  blimp_x2w_if.sub                      mul_x2w,
  input  logic [blimp_pkg::SEQ_W-1:0]   head_seq,
  // Commit to register file, scoreboard and counter
  output logic                          commit_val,
  output logic [blimp_pkg::REG_AW-1:0]  commit_waddr,
  output logic [blimp_pkg::DATA_W-1:0]  commit_wdata,
  // Instruction trace
  output logic                          trace_val,
  output logic [blimp_pkg::SEQ_W-1:0]   trace_seq,
  output logic [blimp_pkg::REG_AW-1:0]  trace_waddr,
  output logic [blimp_pkg::DATA_W-1:0]  trace_wdata
);

  import blimp_pkg::*;

  logic [ROB_DEPTH-1:0] done_q;
  logic [REG_AW-1:0]    waddr_q [ROB_DEPTH];
  logic [DATA_W-1:0]    wdata_q [ROB_DEPTH];

  // ------------------------------
  // Done flags
  // ------------------------------

  // Head clears first, completions then mark their entries
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= '0;
    end else begin
      if (commit_val) begin
        done_q[head_seq] <= 1'b0;
      end
      if (alu_x2w.val) begin
        done_q[alu_x2w.seq_num] <= 1'b1;
      end
      if (mul_x2w.val) begin
        done_q[mul_x2w.seq_num] <= 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (alu_x2w.val) begin
      waddr_q[alu_x2w.seq_num] <= alu_x2w.waddr;
      wdata_q[alu_x2w.seq_num] <= alu_x2w.wdata;
    end
    if (mul_x2w.val) begin
      waddr_q[mul_x2w.seq_num] <= mul_x2w.waddr;
      wdata_q[mul_x2w.seq_num] <= mul_x2w.wdata;
    end
  end

  // ------------------------------
  // In-order commit and trace
  // ------------------------------

  assign commit_val   = done_q[head_seq];
  assign commit_waddr = waddr_q[head_seq];
  assign commit_wdata = wdata_q[head_seq];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_val <= 1'b0;
    end else begin
      trace_val <= commit_val;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_val) begin
      trace_seq   <= head_seq;
      trace_waddr <= commit_waddr;
      trace_wdata <= commit_wdata;
    end
  end

  // Tags come from the counter, so a live entry is never hit twice
  a_alu_fresh_entry : assert property (@(posedge clk) disable iff (!rst_n)
    alu_x2w.val |-> !done_q[alu_x2w.seq_num]);

  a_mul_fresh_entry : assert property (@(posedge clk) disable iff (!rst_n)
    mul_x2w.val |-> !done_q[mul_x2w.seq_num]);

endmodule

/* logic/blimp_core.sv */
/*
 * Core slice top level: decode/issue, ALU and multiplier pipes, commit.
 * Instructions enter on plain ports and are held while inst_stall is high.
 * The trace reports the sequence number in place of a pc.
 */

`timescale 1ns/1ps

module blimp_core (
  input  logic                          clk,
  input  logic                          rst_n,
  // Instruction in
  input  logic                          inst_val,
  input  blimp_pkg::blimp_op_e          inst_op,
  input  logic [blimp_pkg::REG_AW-1:0]  inst_waddr,
  input  logic [blimp_pkg::REG_AW-1:0]  inst_raddr0,
  input  logic [blimp_pkg::REG_AW-1:0]  inst_raddr1,
  input  logic [blimp_pkg::IMM_W-1:0]   inst_imm,
  output logic                          inst_stall,
  // Instruction trace
  output logic                          trace_val,
  output logic [blimp_pkg::SEQ_W-1:0]   trace_seq,
  output logic [blimp_pkg::REG_AW-1:0]  trace_waddr,
  output logic [blimp_pkg::DATA_W-1:0]  trace_wdata
);

  import blimp_pkg::*;

  // ------------------------------
  // Internal wires
  // ------------------------------

  logic [REG_AW-1:0] raddr0;
  logic [REG_AW-1:0] raddr1;
  logic [DATA_W-1:0] rdata0;
  logic [DATA_W-1:0] rdata1;
  logic [SEQ_W-1:0]  alloc_seq;
  logic [SEQ_W-1:0]  head_seq;
  logic              rob_full;
  logic              issue;
  logic              commit_val;
  logic [REG_AW-1:0] commit_waddr;
  logic [DATA_W-1:0] commit_wdata;
  // ALU dispatch
  logic              alu_val;
  blimp_op_e         alu_op;
  logic [DATA_W-1:0] alu_a;
  logic [DATA_W-1:0] alu_b;
  logic [SEQ_W-1:0]  alu_seq_num;
  logic [REG_AW-1:0] alu_waddr;
  // Multiplier dispatch
  logic              mul_val;
  logic [DATA_W-1:0] mul_a;
  logic [DATA_W-1:0] mul_b;
  logic [SEQ_W-1:0]  mul_seq_num;
  logic [REG_AW-1:0] mul_waddr;

  // Completion paths
  blimp_x2w_if alu_x2w ();
  blimp_x2w_if mul_x2w ();

  // ------------------------------
  // Units
  // ------------------------------

  blimp_decode_issue i_decode_issue (.*);

  blimp_seq_counter i_seq_counter (.*);

  blimp_reg_file i_reg_file (
    .wen   (commit_val),
    .waddr (commit_waddr),
    .wdata (commit_wdata),
    .*
  );

  blimp_alu_unit i_alu_unit (
    .op      (alu_op),
    .a       (alu_a),
    .b       (alu_b),
    .seq_num (alu_seq_num),
    .waddr   (alu_waddr),
    .x2w     (alu_x2w),
    .*
  );

  blimp_mul_unit i_mul_unit (
    .a       (mul_a),
    .b       (mul_b),
    .seq_num (mul_seq_num),
    .waddr   (mul_waddr),
    .x2w     (mul_x2w),
    .*
  );

  blimp_writeback_commit i_writeback_commit (
    .alu_x2w (alu_x2w),
    .mul_x2w (mul_x2w),
    .*
  );

endmodule

/* tb/blimp_core_tb.sv */
/*
 * Table-driven testbench for the core slice, checked against a golden register model.
 * Expected traces follow table order; sequence numbers wrap modulo ROB_DEPTH.
 * Stops at the first mismatch, hang limit scales with the table length.
 */

`timescale 1ns/1ps

module blimp_core_tb;

  import blimp_pkg::*;

  localparam int NUM_DIRECTED   = 30;
  localparam int NUM_RANDOM     = 40;
  localparam int NUM_ENTRIES    = NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = 20 * NUM_ENTRIES + 50;

  logic              clk;
  logic              rst_n;
  logic              inst_val;
  blimp_op_e         inst_op;
  logic [REG_AW-1:0] inst_waddr;
  logic [REG_AW-1:0] inst_raddr0;
  logic [REG_AW-1:0] inst_raddr1;
  logic [IMM_W-1:0]  inst_imm;
  logic              inst_stall;
  logic              trace_val;
  logic [SEQ_W-1:0]  trace_seq;
  logic [REG_AW-1:0] trace_waddr;
  logic [DATA_W-1:0] trace_wdata;

  // Stimulus table
  string             tab_name   [NUM_ENTRIES];
  blimp_op_e         tab_op     [NUM_ENTRIES];
  logic [REG_AW-1:0] tab_waddr  [NUM_ENTRIES];
  logic [REG_AW-1:0] tab_raddr0 [NUM_ENTRIES];
  logic [REG_AW-1:0] tab_raddr1 [NUM_ENTRIES];
  logic [IMM_W-1:0]  tab_imm    [NUM_ENTRIES];
  int                n_entries;

  // Expected traces, in commit order
  string             exp_name_q  [$];
  logic [SEQ_W-1:0]  exp_seq_q   [$];
  logic [REG_AW-1:0] exp_waddr_q [$];
  logic [DATA_W-1:0] exp_wdata_q [$];
  logic [DATA_W-1:0] golden_regs [NUM_REGS];

  string             cur_name;
  logic [SEQ_W-1:0]  cur_seq;
  logic [REG_AW-1:0] cur_waddr;
  logic [DATA_W-1:0] cur_wdata;
  logic [31:0]       rng_state;
  int                traced_count;
  int                stall_cycles;
  int                cycle_count;
  int                error_count;

  blimp_core i_blimp_core (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic abort_run(input string why);
    error_count++;
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic value_mismatch(input string test_name, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
    abort_run($sformatf("[FAIL] %s: %s expected 0x%08h actual 0x%08h",
                        test_name, field, expected, actual));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_entry(input string name, input blimp_op_e op, input int w,
                           input int r0, input int r1, input int imm);
    tab_name[n_entries]   = name;
    tab_op[n_entries]     = op;
    tab_waddr[n_entries]  = REG_AW'(w);
    tab_raddr0[n_entries] = REG_AW'(r0);
    tab_raddr1[n_entries] = REG_AW'(r1);
    tab_imm[n_entries]    = IMM_W'(imm);
    n_entries++;
  endtask

  // Architectural result of one instruction
  function automatic logic [DATA_W-1:0] expected_result(input blimp_op_e op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input logic [IMM_W-1:0] imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_LI:   return DATA_W'(imm);
      default: return a * b;
    endcase
  endfunction

  task automatic build_table();
    int d;
    n_entries = 0;
    // Basic ALU ops
    add_entry("alu_basic", OP_LI, 1, 0, 0, 'h1234);
    add_entry("alu_basic", OP_LI, 2, 0, 0, 'h00ff);
    add_entry("alu_basic", OP_ADD, 3, 1, 2, 0);
    add_entry("alu_basic", OP_SUB, 4, 2, 1, 0);
    add_entry("alu_basic", OP_AND, 5, 1, 2, 0);
    add_entry("alu_basic", OP_LI, 6, 0, 0, 'hffff);
    add_entry("alu_basic", OP_ADD, 7, 6, 6, 0);
    // Slow multiply overtaken by independent ALU ops
    add_entry("mul_reorder", OP_MUL, 0, 6, 7, 0);
    add_entry("mul_reorder", OP_LI, 1, 0, 0, 'h0007);
    add_entry("mul_reorder", OP_AND, 2, 4, 5, 0);
    add_entry("mul_reorder", OP_SUB, 3, 5, 4, 0);
    // mul -> add -> mul through the scoreboard
    add_entry("dep_chain", OP_LI, 1, 0, 0, 3);
    add_entry("dep_chain", OP_LI, 2, 0, 0, 11);
    add_entry("dep_chain", OP_MUL, 3, 1, 2, 0);
    add_entry("dep_chain", OP_ADD, 4, 3, 1, 0);
    add_entry("dep_chain", OP_MUL, 5, 4, 4, 0);
    // Back-to-back multiplies into the free registers
    add_entry("mul_stream", OP_LI, 1, 0, 0, 'h1003);
    add_entry("mul_stream", OP_LI, 2, 0, 0, 'h0201);
    for (int k = 0; k < 12; k++) begin
      d = k % 6;
      if (d != 0) begin
        d = d + 2;
      end
      add_entry("mul_stream", OP_MUL, d, 1, 2, 0);
    end
    // Random mix
    rng_state = 32'ha39e;
    for (int k = 0; k < NUM_RANDOM; k++) begin
      rng_state = xorshift32(rng_state);
      add_entry("random", blimp_op_e'(3'(rng_state % 32'd5)), int'(rng_state[10:8]),
                int'(rng_state[13:11]), int'(rng_state[16:14]), 0);
      rng_state = xorshift32(rng_state);
      tab_imm[n_entries-1] = rng_state[IMM_W-1:0];
    end
  endtask

  // Table order is commit order
  task automatic run_golden();
    logic [DATA_W-1:0] result;
    for (int r = 0; r < NUM_REGS; r++) begin
      golden_regs[r] = '0;
    end
    for (int i = 0; i < n_entries; i++) begin
      result = expected_result(tab_op[i], golden_regs[tab_raddr0[i]],
                               golden_regs[tab_raddr1[i]], tab_imm[i]);
      golden_regs[tab_waddr[i]] = result;
      exp_name_q.push_back(tab_name[i]);
      exp_seq_q.push_back(SEQ_W'(i % ROB_DEPTH));
      exp_waddr_q.push_back(tab_waddr[i]);
      exp_wdata_q.push_back(result);
    end
  endtask

  // ------------------------------
  // Monitor and hang guard
  // ------------------------------

  always @(negedge clk) begin
    if (rst_n && trace_val) begin
      if (exp_seq_q.size() == 0) begin
        abort_run("trace_val rose with no instruction outstanding");
      end else begin
        cur_name  = exp_name_q.pop_front();
        cur_seq   = exp_seq_q.pop_front();
        cur_waddr = exp_waddr_q.pop_front();
        cur_wdata = exp_wdata_q.pop_front();
        assert (trace_seq == cur_seq)
          else value_mismatch(cur_name, "trace_seq", 32'(cur_seq), 32'(trace_seq));
        assert (trace_waddr == cur_waddr)
          else value_mismatch(cur_name, "trace_waddr", 32'(cur_waddr), 32'(trace_waddr));
        assert (trace_wdata == cur_wdata)
          else value_mismatch(cur_name, "trace_wdata", cur_wdata, trace_wdata);
        traced_count++;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("Timeout: only %0d of %0d instructions traced after %0d cycles",
                            traced_count, n_entries, cycle_count));
      end
    end
  end

  // ------------------------------
  // Driver
  // ------------------------------

  initial begin
    rst_n          = 1'b0;
    inst_val       = 1'b0;
    inst_op        = OP_ADD;
    inst_waddr     = '0;
    inst_raddr0    = '0;
    inst_raddr1    = '0;
    inst_imm       = '0;
    traced_count   = 0;
    stall_cycles   = 0;
    cycle_count    = 0;
    error_count    = 0;
    build_table();
    run_golden();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!inst_stall) else abort_run("inst_stall is high right after reset");
    assert (!trace_val) else abort_run("trace_val is high right after reset");
    for (int i = 0; i < n_entries; i++) begin
      @(negedge clk);
      inst_val    = 1'b1;
      inst_op     = tab_op[i];
      inst_waddr  = tab_waddr[i];
      inst_raddr0 = tab_raddr0[i];
      inst_raddr1 = tab_raddr1[i];
      inst_imm    = tab_imm[i];
      // Hold until the next rising edge takes it
      while (inst_stall) begin
        stall_cycles++;
        @(negedge clk);
      end
    end
    @(negedge clk);
    inst_val = 1'b0;
    while (traced_count < n_entries) begin
      @(negedge clk);
    end
    // Window for any stray trace
    repeat (2 * MUL_STAGES) @(negedge clk);
    assert (stall_cycles > 0)
      else abort_run("inst_stall never rose, so no dependency or full stall was exercised");
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* project.f */
logic/blimp_pkg.sv
logic/blimp_x2w_if.sv
logic/blimp_reg_file.sv
logic/blimp_seq_counter.sv
logic/blimp_decode_issue.sv
logic/blimp_alu_unit.sv
logic/blimp_mul_unit.sv
logic/blimp_writeback_commit.sv
logic/blimp_core.sv
tb/blimp_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = blimp_core_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
